/* source/rammodel_pkg.sv */
package rammodel_pkg;

    // Every word on the host link is this wide
    localparam int STREAM_WORD_WIDTH = 32;

    // Header layout: channel code on top, ID below it, per-channel info at the bottom
    localparam int HDR_ID_LSB = 16;
    localparam int HDR_CHAN_LSB = 30;
    localparam int HDR_ID_BITS = HDR_CHAN_LSB - HDR_ID_LSB;

    typedef logic [STREAM_WORD_WIDTH-1:0] stream_word_t;

    // ID field of a header, wide enough for any supported AXI ID
    typedef logic [HDR_ID_BITS-1:0] hdr_id_t;

    // Low half of a header, rlast for R and the burst length for AR
    typedef logic [HDR_ID_LSB-1:0] hdr_info_t;

    typedef logic [7:0] burst_len_t;

    typedef enum logic [1:0] {
        CHAN_NONE = 2'd0,
        CHAN_AR   = 2'd1,
        CHAN_R    = 2'd2,
        CHAN_RSVD = 2'd3
    } chan_code_t;

    // HEAD sends the header, WORD_1 the low payload word, WORD_2 the high one
    typedef enum logic [1:0] {
        ENC_IDLE   = 2'd0,
        ENC_HEAD   = 2'd1,
        ENC_WORD_1 = 2'd2,
        ENC_WORD_2 = 2'd3
    } enc_state_t;

    typedef struct packed {
        stream_word_t word;
        logic         last;
    } stream_beat_t;

    function automatic stream_word_t make_header(
        input chan_code_t chan,
        input hdr_id_t    id,
        input hdr_info_t  info
    );
        stream_word_t w;
        w = '0;
        w[HDR_CHAN_LSB +: 2] = chan;
        w[HDR_ID_LSB +: HDR_ID_BITS] = id;
        w[HDR_ID_LSB-1:0] = info;
        return w;
    endfunction

endpackage

/* source/rammodel_encoder_ar.sv */
`timescale 1ns/1ps

module rammodel_encoder_ar #(
    parameter int ADDR_WIDTH = 32,
    parameter int ID_WIDTH   = 4
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       arvalid,
    output logic                       arready,
    input  logic [ID_WIDTH-1:0]        arid,
    input  logic [ADDR_WIDTH-1:0]      araddr,
    input  rammodel_pkg::burst_len_t   arlen,

    output rammodel_pkg::stream_beat_t beat,
    output logic                       beat_valid,
    input  logic                       beat_ready,

    output logic                       idle
);
    import rammodel_pkg::*;

    // A 32-bit address fits in one word, so WORD_2 is never visited
    localparam bit ADDR_32 = ADDR_WIDTH <= 32;

    enc_state_t state;
    enc_state_t state_next;

    logic [ADDR_WIDTH-1:0] addr_q;

    logic ar_fire;
    logic beat_fire;

    assign ar_fire   = arvalid && arready;
    assign beat_fire = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENC_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ENC_IDLE: begin
                if (ar_fire) begin
                    state_next = ENC_HEAD;
                end
            end
            ENC_HEAD: begin
                if (beat_fire) begin
                    state_next = ENC_WORD_1;
                end
            end
            ENC_WORD_1: begin
                if (beat_fire) begin
                    state_next = ADDR_32 ? ENC_IDLE : ENC_WORD_2;
                end
            end
            ENC_WORD_2: begin
                if (beat_fire) begin
                    state_next = ENC_IDLE;
                end
            end
            default: state_next = ENC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ar_fire) begin
            addr_q <= araddr;
        end
    end

    // The outgoing word is registered and loaded one step ahead of its state
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            beat.word <= make_header(CHAN_AR, hdr_id_t'(arid), hdr_info_t'(arlen));
            beat.last <= 1'b0;
        end else if (beat_fire && state == ENC_HEAD) begin
            beat.word <= addr_q[31:0];
            beat.last <= ADDR_32;
        end else if (beat_fire && state == ENC_WORD_1) begin
            beat.word <= addr_q[ADDR_WIDTH-1 -: 32];
            beat.last <= 1'b1;
        end
    end

    assign arready    = state == ENC_IDLE;
    assign beat_valid = state != ENC_IDLE;
    assign idle       = state == ENC_IDLE;

endmodule

/* source/rammodel_encoder_r.sv */
`timescale 1ns/1ps

module rammodel_encoder_r #(
    parameter int DATA_WIDTH = 64,
    parameter int ID_WIDTH   = 4
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       rvalid,
    output logic                       rready,
    input  logic [ID_WIDTH-1:0]        rid,
    input  logic [DATA_WIDTH-1:0]      rdata,
    input  logic                       rlast,

    output rammodel_pkg::stream_beat_t beat,
    output logic                       beat_valid,
    input  logic                       beat_ready,

    output logic                       idle
);
    import rammodel_pkg::*;

    localparam bit DATA_32 = DATA_WIDTH <= 32;

    enc_state_t state;
    enc_state_t state_next;

    logic [DATA_WIDTH-1:0] data_q;

    logic r_fire;
    logic beat_fire;

    assign r_fire    = rvalid && rready;
    assign beat_fire = beat_valid && beat_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ENC_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ENC_IDLE: begin
                if (r_fire) begin
                    state_next = ENC_HEAD;
                end
            end
            ENC_HEAD: begin
                if (beat_fire) begin
                    state_next = ENC_WORD_1;
                end
            end
            ENC_WORD_1: begin
                // Narrow data ends the packet after one data word
                if (beat_fire) begin
                    state_next = DATA_32 ? ENC_IDLE : ENC_WORD_2;
                end
            end
            ENC_WORD_2: begin
                if (beat_fire) begin
                    state_next = ENC_IDLE;
                end
            end
            default: state_next = ENC_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (r_fire) begin
            data_q <= rdata;
        end
    end

    // Header first, then the low data word, then the high one for wide data
    always_ff @(posedge clk) begin
        if (r_fire) begin
            beat.word <= make_header(CHAN_R, hdr_id_t'(rid), hdr_info_t'(rlast));
            beat.last <= 1'b0;
        end else if (beat_fire && state == ENC_HEAD) begin
            beat.word <= data_q[31:0];
            beat.last <= DATA_32;
        end else if (beat_fire && state == ENC_WORD_1) begin
            beat.word <= data_q[DATA_WIDTH-1 -: 32];
            beat.last <= 1'b1;
        end
    end

    // Ready only in IDLE, so a new beat is never taken while a packet is pending
    assign rready     = state == ENC_IDLE;
    assign beat_valid = state != ENC_IDLE;
    assign idle       = state == ENC_IDLE;

endmodule

/* source/rammodel_stream_arbiter.sv */
`timescale 1ns/1ps

module rammodel_stream_arbiter (
    input  logic                       clk,
    input  logic                       rst,

    input  rammodel_pkg::stream_beat_t ar_beat,
    input  logic                       ar_valid,
    output logic                       ar_ready,

    input  rammodel_pkg::stream_beat_t r_beat,
    input  logic                       r_valid,
    output logic                       r_ready,

    output rammodel_pkg::stream_beat_t out_beat,
    output logic                       out_valid,
    input  logic                       out_ready,

    output logic                       busy
);

    // Source select: 0 is the AR encoder, 1 is the R encoder
    logic locked_q;
    logic grant_q;
    logic prefer_r_q;
    logic sel;
    logic out_fire;

    always_comb begin
        if (locked_q) begin
            sel = grant_q;
        end else if (ar_valid && r_valid) begin
            sel = prefer_r_q;
        end else begin
            sel = r_valid;
        end
    end

    assign out_valid = sel ? r_valid : ar_valid;
    assign out_beat  = sel ? r_beat : ar_beat;
    assign ar_ready  = out_ready && !sel;
    assign r_ready   = out_ready && sel;

    assign out_fire = out_valid && out_ready;

    // The grant is taken when a source first offers a word and held until its last word is accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            locked_q   <= 1'b0;
            grant_q    <= 1'b0;
            prefer_r_q <= 1'b0;
        end else if (out_valid) begin
            if (out_fire && out_beat.last) begin
                locked_q   <= 1'b0;
                prefer_r_q <= !sel;
            end else begin
                locked_q <= 1'b1;
                grant_q  <= sel;
            end
        end
    end

    assign busy = locked_q;

endmodule

/* source/rammodel_read_encoder.sv */
`timescale 1ns/1ps

module rammodel_read_encoder #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 64,
    parameter int ID_WIDTH   = 4
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       arvalid,
    output logic                       arready,
    input  logic [ID_WIDTH-1:0]        arid,
    input  logic [ADDR_WIDTH-1:0]      araddr,
    input  rammodel_pkg::burst_len_t   arlen,

    input  logic                       rvalid,
    output logic                       rready,
    input  logic [ID_WIDTH-1:0]        rid,
    input  logic [DATA_WIDTH-1:0]      rdata,
    input  logic                       rlast,

    output logic                       out_valid,
    input  logic                       out_ready,
    output rammodel_pkg::stream_word_t out_word,
    output logic                       out_last,

    output logic                       idle
);
    import rammodel_pkg::*;

    stream_beat_t ar_beat;
    logic         ar_beat_valid;
    logic         ar_beat_ready;
    logic         ar_idle;

    stream_beat_t r_beat;
    logic         r_beat_valid;
    logic         r_beat_ready;
    logic         r_idle;

    stream_beat_t out_beat;
    logic         arb_busy;

    rammodel_encoder_ar #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) i_enc_ar (
        .clk        (clk),
        .rst        (rst),
        .arvalid    (arvalid),
        .arready    (arready),
        .arid       (arid),
        .araddr     (araddr),
        .arlen      (arlen),
        .beat       (ar_beat),
        .beat_valid (ar_beat_valid),
        .beat_ready (ar_beat_ready),
        .idle       (ar_idle)
    );

    rammodel_encoder_r #(
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) i_enc_r (
        .clk        (clk),
        .rst        (rst),
        .rvalid     (rvalid),
        .rready     (rready),
        .rid        (rid),
        .rdata      (rdata),
        .rlast      (rlast),
        .beat       (r_beat),
        .beat_valid (r_beat_valid),
        .beat_ready (r_beat_ready),
        .idle       (r_idle)
    );

    rammodel_stream_arbiter i_arb (
        .clk       (clk),
        .rst       (rst),
        .ar_beat   (ar_beat),
        .ar_valid  (ar_beat_valid),
        .ar_ready  (ar_beat_ready),
        .r_beat    (r_beat),
        .r_valid   (r_beat_valid),
        .r_ready   (r_beat_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .busy      (arb_busy)
    );

    assign out_word = out_beat.word;
    assign out_last = out_beat.last;

    // Idle only when no encoder holds a packet and no packet is half sent
    assign idle = ar_idle && r_idle && !arb_busy;

endmodule

/* dv/rammodel_read_encoder_checker.sv */
`timescale 1ns/1ps

module rammodel_read_encoder_checker #(
    parameter int ADDR_WIDTH = 32,
    parameter int DATA_WIDTH = 64
) (
    input logic                       clk,
    input logic                       rst,
    input logic                       arvalid,
    input logic                       arready,
    input logic                       rvalid,
    input logic                       rready,
    input logic                       out_valid,
    input logic                       out_ready,
    input rammodel_pkg::stream_word_t out_word,
    input logic                       out_last,
    input logic                       idle
);
    import rammodel_pkg::*;

    // Index of the final word, with the header at index 0
    localparam int AR_LAST_IDX = ADDR_WIDTH / 32;
    localparam int R_LAST_IDX  = DATA_WIDTH / 32;

    int unsigned fail_count = 0;

    logic       out_fire;
    logic       in_pkt;
    chan_code_t pkt_chan;
    logic [1:0] word_idx;
    logic [1:0] last_idx;
    logic       pkt_done;
    logic       ar_pending;
    logic       r_pending;

    assign out_fire = out_valid && out_ready;
    assign last_idx = (pkt_chan == CHAN_AR) ? 2'(AR_LAST_IDX) : 2'(R_LAST_IDX);
    assign pkt_done = out_fire && in_pkt && out_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_pkt   <= 1'b0;
            pkt_chan <= CHAN_NONE;
            word_idx <= '0;
        end else if (out_fire) begin
            if (!in_pkt) begin
                pkt_chan <= chan_code_t'(out_word[HDR_CHAN_LSB +: 2]);
            end
            in_pkt   <= !out_last;
            word_idx <= out_last ? 2'd0 : word_idx + 2'd1;
        end
    end

    // A transfer stays pending until the last word of its packet leaves the output
    always_ff @(posedge clk) begin
        if (rst) begin
            ar_pending <= 1'b0;
            r_pending  <= 1'b0;
        end else begin
            if (arvalid && arready) begin
                ar_pending <= 1'b1;
            end else if (pkt_done && pkt_chan == CHAN_AR) begin
                ar_pending <= 1'b0;
            end
            if (rvalid && rready) begin
                r_pending <= 1'b1;
            end else if (pkt_done && pkt_chan == CHAN_R) begin
                r_pending <= 1'b0;
            end
        end
    end

    a_reset_state: assert property (@(posedge clk)
        rst |=> (!out_valid && idle && arready && rready))
        else begin
            fail_count++;
            $error("DUT is not idle with both channels ready after reset");
        end

    a_hold_stable: assert property (@(posedge clk) disable iff (rst)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_word) && $stable(out_last)))
        else begin
            fail_count++;
            $error("Output word changed or dropped while out_ready was low");
        end

    a_header_chan: assert property (@(posedge clk) disable iff (rst)
        (out_fire && !in_pkt) |->
            ((out_word[HDR_CHAN_LSB +: 2] == CHAN_AR || out_word[HDR_CHAN_LSB +: 2] == CHAN_R)
             && !out_last))
        else begin
            fail_count++;
            $error("Packet header has a bad channel code or is marked last");
        end

    // A packet from another source slipping in would end at the wrong position
    a_packet_length: assert property (@(posedge clk) disable iff (rst)
        (out_fire && in_pkt) |-> (out_last == (word_idx == last_idx)))
        else begin
            fail_count++;
            $error("Packet length does not match the channel of its header");
        end

    a_ar_ready_busy: assert property (@(posedge clk) disable iff (rst)
        ar_pending |-> !arready)
        else begin
            fail_count++;
            $error("arready high while an AR packet is still pending");
        end

    a_r_ready_busy: assert property (@(posedge clk) disable iff (rst)
        r_pending |-> !rready)
        else begin
            fail_count++;
            $error("rready high while an R packet is still pending");
        end

endmodule

bind rammodel_read_encoder rammodel_read_encoder_checker #(
    .ADDR_WIDTH (ADDR_WIDTH),
    .DATA_WIDTH (DATA_WIDTH)
) i_checker (
    .clk       (clk),
    .rst       (rst),
    .arvalid   (arvalid),
    .arready   (arready),
    .rvalid    (rvalid),
    .rready    (rready),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_word  (out_word),
    .out_last  (out_last),
    .idle      (idle)
);

/* dv/rammodel_read_encoder_tb.sv */
`timescale 1ns/1ps

module rammodel_read_encoder_tb;
    import rammodel_pkg::*;

    localparam int ADDR_WIDTH    = 32;
    localparam int DATA_WIDTH    = 64;
    localparam int ID_WIDTH      = 4;
    localparam int DRAIN_TIMEOUT = 500;

    logic                  clk;
    logic                  rst;
    logic                  arvalid;
    logic                  arready;
    logic [ID_WIDTH-1:0]   arid;
    logic [ADDR_WIDTH-1:0] araddr;
    burst_len_t            arlen;
    logic                  rvalid;
    logic                  rready;
    logic [ID_WIDTH-1:0]   rid;
    logic [DATA_WIDTH-1:0] rdata;
    logic                  rlast;
    logic                  out_valid;
    logic                  out_ready;
    stream_word_t          out_word;
    logic                  out_last;
    logic                  idle;

    integer       seed;
    int           errors;
    int           tests_run;
    int           tests_failed;
    int           accepted;
    int           delivered;
    string        test_name;
    stream_beat_t ar_exp[$];
    stream_beat_t r_exp[$];
    logic         in_pkt;
    logic         ar_hold;
    logic         r_hold;
    bit           check_alternation;
    chan_code_t   cur_chan;
    chan_code_t   prev_chan;

    rammodel_read_encoder #(
        .ADDR_WIDTH (ADDR_WIDTH),
        .DATA_WIDTH (DATA_WIDTH),
        .ID_WIDTH   (ID_WIDTH)
    ) i_dut (
        .clk       (clk),
        .rst       (rst),
        .arvalid   (arvalid),
        .arready   (arready),
        .arid      (arid),
        .araddr    (araddr),
        .arlen     (arlen),
        .rvalid    (rvalid),
        .rready    (rready),
        .rid       (rid),
        .rdata     (rdata),
        .rlast     (rlast),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_word  (out_word),
        .out_last  (out_last),
        .idle      (idle)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic int total_errors();
        return errors + i_dut.i_checker.fail_count;
    endfunction

    function automatic bit chance(input int pct);
        return ($unsigned($random(seed)) % 100) < pct;
    endfunction

    // Header: channel code in 31:30, ID from bit 16, burst length in 7:0
    task automatic expect_ar(input logic [ID_WIDTH-1:0] id, input logic [ADDR_WIDTH-1:0] addr,
                             input burst_len_t len);
        stream_beat_t b;
        b.word = '0;
        b.word[HDR_CHAN_LSB +: 2] = CHAN_AR;
        b.word[HDR_ID_LSB +: ID_WIDTH] = id;
        b.word[7:0] = len;
        b.last = 1'b0;
        ar_exp.push_back(b);
        b.word = addr[31:0];
        b.last = 1'b1;
        ar_exp.push_back(b);
    endtask

    // R header carries rlast in bit 0, then the low and the high data word
    task automatic expect_r(input logic [ID_WIDTH-1:0] id, input logic [DATA_WIDTH-1:0] data,
                            input logic last);
        stream_beat_t b;
        b.word = '0;
        b.word[HDR_CHAN_LSB +: 2] = CHAN_R;
        b.word[HDR_ID_LSB +: ID_WIDTH] = id;
        b.word[0] = last;
        b.last = 1'b0;
        r_exp.push_back(b);
        b.word = data[31:0];
        r_exp.push_back(b);
        b.word = data[63:32];
        b.last = 1'b1;
        r_exp.push_back(b);
    endtask

    task automatic check_output();
        stream_beat_t exp;
        chan_code_t   chan;
        bit           have_exp;
        if (!in_pkt) begin
            chan = chan_code_t'(out_word[HDR_CHAN_LSB +: 2]);
            if (check_alternation && prev_chan != CHAN_NONE) begin
                assert (chan != prev_chan) else begin
                    errors++;
                    $display("MISMATCH %s: expected channel other than %s, actual %s",
                             test_name, prev_chan.name(), chan.name());
                end
            end
            prev_chan = chan;
            cur_chan = chan;
        end
        have_exp = (cur_chan == CHAN_AR && ar_exp.size() > 0) ||
                   (cur_chan == CHAN_R && r_exp.size() > 0);
        assert (have_exp) else begin
            errors++;
            $display("%s: output word %h arrived while no packet was expected on its channel",
                     test_name, out_word);
        end
        if (have_exp) begin
            exp = (cur_chan == CHAN_AR) ? ar_exp.pop_front() : r_exp.pop_front();
            assert (out_word == exp.word) else begin
                errors++;
                $display("MISMATCH %s: expected word %h, actual %h", test_name, exp.word, out_word);
            end
            assert (out_last == exp.last) else begin
                errors++;
                $display("MISMATCH %s: expected last %b, actual %b", test_name, exp.last, out_last);
            end
        end
        in_pkt = !out_last;
        if (out_last) begin
            delivered++;
        end
    endtask

    // A valid that was not accepted stays up with the same payload
    task automatic drive_inputs(input int ar_pct, input int r_pct, input int ready_pct);
        if (!ar_hold) begin
            arvalid = chance(ar_pct);
            arid    = ID_WIDTH'($random(seed));
            araddr  = $random(seed);
            arlen   = 8'($random(seed));
        end
        if (!r_hold) begin
            rvalid = chance(r_pct);
            rid    = ID_WIDTH'($random(seed));
            rdata  = {$random(seed), $random(seed)};
            rlast  = chance(50);
        end
        out_ready = chance(ready_pct);
    endtask

    // Outputs come from registers, so they already hold what the next edge will take
    task automatic observe();
        if (arvalid && arready) begin
            expect_ar(arid, araddr, arlen);
            accepted++;
        end
        if (rvalid && rready) begin
            expect_r(rid, rdata, rlast);
            accepted++;
        end
        ar_hold = arvalid && !arready;
        r_hold  = rvalid && !rready;
        if (out_valid && out_ready) begin
            check_output();
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (!(idle && !ar_hold && !r_hold && ar_exp.size() == 0 && r_exp.size() == 0) &&
               waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            drive_inputs(0, 0, 100);
            observe();
            waited++;
        end
        assert (waited < DRAIN_TIMEOUT) else begin
            errors++;
            $display("%s: timed out waiting for the DUT to deliver all pending packets",
                     test_name);
        end
    endtask

    task automatic run_test(input string name, input int cycles, input int ar_pct,
                            input int r_pct, input int ready_pct, input bit alternate);
        int errors_before;
        errors_before = total_errors();
        test_name = name;
        accepted = 0;
        delivered = 0;
        prev_chan = CHAN_NONE;
        check_alternation = alternate;
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            drive_inputs(ar_pct, r_pct, ready_pct);
            observe();
        end
        // The tail of a run has one channel running dry, so alternation no longer holds
        check_alternation = 1'b0;
        drain();
        assert (delivered == accepted) else begin
            errors++;
            $display("MISMATCH %s: expected %0d packets, actual %0d", name, accepted, delivered);
        end
        tests_run++;
        if (total_errors() == errors_before) begin
            $display("test %s: %0d packets delivered, passed", name, delivered);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, total_errors() - errors_before);
        end
    endtask

    initial begin
        seed         = 32'h0718035e;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        accepted     = 0;
        delivered    = 0;
        rst          = 1'b1;
        arvalid      = 1'b0;
        arid         = '0;
        araddr       = '0;
        arlen        = '0;
        rvalid       = 1'b0;
        rid          = '0;
        rdata        = '0;
        rlast        = 1'b0;
        out_ready    = 1'b0;
        in_pkt       = 1'b0;
        ar_hold      = 1'b0;
        r_hold       = 1'b0;
        cur_chan     = CHAN_NONE;
        prev_chan    = CHAN_NONE;
        check_alternation = 1'b0;

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        run_test("r_packets", 200, 0, 60, 100, 1'b0);
        run_test("ar_packets", 200, 60, 0, 100, 1'b0);
        run_test("round_robin", 200, 100, 100, 100, 1'b1);
        run_test("back_pressure", 600, 50, 50, 40, 1'b0);

        $display("tests run: %0d, tests failed: %0d, testbench errors: %0d, assertion failures: %0d",
                 tests_run, tests_failed, errors, i_dut.i_checker.fail_count);
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* flist.f */
source/rammodel_pkg.sv
source/rammodel_encoder_ar.sv
source/rammodel_encoder_r.sv
source/rammodel_stream_arbiter.sv
source/rammodel_read_encoder.sv
dv/rammodel_read_encoder_checker.sv
dv/rammodel_read_encoder_tb.sv

/* Bender.yml */
package:
  name: rammodel_read_encoder

sources:
  - files:
      - source/rammodel_pkg.sv
      - source/rammodel_encoder_ar.sv
      - source/rammodel_encoder_r.sv
      - source/rammodel_stream_arbiter.sv
      - source/rammodel_read_encoder.sv
  - target: test
    files:
      - dv/rammodel_read_encoder_checker.sv
      - dv/rammodel_read_encoder_tb.sv
